/* project.f */
+incdir+src
src/prbs_pkg.sv
src/csr_pkg.sv
src/prbs_csr.sv
src/prbs_lane_gen.sv
src/sample_fifo.sv
src/prbs_lane_check.sv
src/prbs_emu_top.sv
tb/tb_clk_gen.sv
tb/prbs_emu_tb.sv

/* Bender.yml */
package:
  name: prbs_emu

sources:
  - include_dirs:
      - src
    files:
      - src/prbs_pkg.sv
      - src/csr_pkg.sv
      - src/prbs_csr.sv
      - src/prbs_lane_gen.sv
      - src/sample_fifo.sv
      - src/prbs_lane_check.sv
      - src/prbs_emu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_clk_gen.sv
      - tb/prbs_emu_tb.sv

/* tb/prbs_emu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_emu_tb import prbs_pkg::*, csr_pkg::*;;

    localparam int ACK_TIMEOUT = 16;
    // Roughly 500 words at up to 6 cycles each, with wide margin
    localparam int WATCHDOG_CYCLES = 20000;
    localparam int RUN_WORDS       = 40;
    localparam int STALL_WORDS     = 200;
    localparam prbs_eqn_t RESET_EQN = 32'h8020_0003;
    localparam prbs_eqn_t NEW_EQN   = 32'h8000_0057;
    localparam lane_word_t ALL_LOCKED = {`PRBS_NUM_LANES{1'b1}};

    logic      emu_clk;
    logic      emu_rst;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    csr_addr_t wb_adr;
    csr_data_t wb_dat_w;
    csr_data_t wb_dat_r;
    logic      wb_ack;

    tb_clk_gen clk_gen_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst)
    );

    prbs_emu_top dut (
        .emu_clk  (emu_clk),
        .emu_rst  (emu_rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_lock(input string name, input lane_word_t exp, input lane_word_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s expected 0x%04h, got 0x%04h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                               $time, name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////////////////////

    // Ack sampled on the falling edge, away from the DUT's update
    task automatic wait_ack(input csr_addr_t adr);
        int waited;
        waited = 0;
        @(negedge emu_clk);
        while (wb_ack !== 1'b1 && waited < ACK_TIMEOUT) begin
            waited++;
            @(negedge emu_clk);
        end
        if (wb_ack !== 1'b1) begin
            fail_run($sformatf("No Wishbone ack within %0d cycles at offset 0x%02h",
                               ACK_TIMEOUT, adr));
        end
    endtask

    task automatic wb_write(input csr_addr_t adr, input csr_data_t data);
        @(posedge emu_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack(adr);
        @(posedge emu_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input csr_addr_t adr, output csr_data_t data);
        @(posedge emu_clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack(adr);
        data = wb_dat_r;
        @(posedge emu_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // Poll the checked-word count until it reaches target
    task automatic wait_words(input count_t target);
        csr_data_t words;
        wb_read(CSR_WORDS, words);
        while (count_t'(words) < target) begin
            wb_read(CSR_WORDS, words);
        end
    endtask

    // A flipped bit is missed once itself, then once per tap it passes
    function automatic count_t errors_per_flip(input prbs_eqn_t eqn);
        return count_t'(1 + $countones(eqn));
    endfunction

    function automatic csr_data_t ctrl_word(input logic en, input logic clr, input gap_t gap);
        return (csr_data_t'(gap) << 4) | (csr_data_t'(clr) << 1) | csr_data_t'(en);
    endfunction

    task automatic expect_clean_lock(input string tag);
        csr_data_t rd;
        wb_read(CSR_LOCK, rd);
        check_lock({tag, " lock"}, ALL_LOCKED, lane_word_t'(rd));
        wb_read(CSR_ERRS, rd);
        check_count({tag, " errors"}, '0, count_t'(rd));
    endtask

    // Inject on one lane and let the flipped bit leave every history
    task automatic inject_and_drain(input lane_idx_t lane);
        csr_data_t words;
        wb_write(CSR_INJ, csr_data_t'(lane));
        wb_read(CSR_WORDS, words);
        wait_words(count_t'(words) + RUN_WORDS);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        csr_data_t rd;
        wb_read(CSR_CTRL, rd);
        check_data("CTRL after reset", ctrl_word(1'b0, 1'b0, 4'd5), rd);
        wb_read(CSR_EQN, rd);
        check_data("EQN after reset", RESET_EQN, rd);
        wb_read(CSR_ERRS, rd);
        check_count("ERRS after reset", '0, count_t'(rd));
        wb_read(CSR_WORDS, rd);
        check_count("WORDS after reset", '0, count_t'(rd));
        wb_read(CSR_LOCK, rd);
        check_lock("LOCK after reset", '0, lane_word_t'(rd));
    endtask

    task automatic test_clean_lock();
        wb_write(CSR_CTRL, ctrl_word(1'b1, 1'b0, 4'd5));
        wait_words(RUN_WORDS);
        expect_clean_lock("clean run");
    endtask

    task automatic test_single_inject();
        lane_idx_t lane;
        csr_data_t rd;
        lane = lane_idx_t'($urandom % `PRBS_NUM_LANES);
        wb_write(CSR_CTRL, ctrl_word(1'b1, 1'b1, 4'd5));
        wait_words(RUN_WORDS);
        expect_clean_lock("before inject");
        inject_and_drain(lane);
        wb_read(CSR_ERRS, rd);
        check_count("single inject errors", errors_per_flip(RESET_EQN), count_t'(rd));
    endtask

    task automatic test_back_pressure();
        wb_write(CSR_CTRL, ctrl_word(1'b1, 1'b1, 4'd0));
        wait_words(STALL_WORDS);
        expect_clean_lock("gap 0");
    endtask

    task automatic test_poly_change();
        lane_idx_t lane_a;
        lane_idx_t lane_b;
        csr_data_t rd;
        lane_a = lane_idx_t'($urandom % `PRBS_NUM_LANES);
        lane_b = lane_idx_t'((int'(lane_a) + 1 + ($urandom % (`PRBS_NUM_LANES - 1)))
                             % `PRBS_NUM_LANES);
        // Clear follows the new taps so stale words are never counted
        wb_write(CSR_EQN, NEW_EQN);
        wb_write(CSR_CTRL, ctrl_word(1'b1, 1'b1, 4'd5));
        wb_read(CSR_EQN, rd);
        check_data("EQN readback", NEW_EQN, rd);
        wait_words(RUN_WORDS);
        expect_clean_lock("new polynomial");
        inject_and_drain(lane_a);
        inject_and_drain(lane_b);
        wb_read(CSR_ERRS, rd);
        check_count("two inject errors", 2 * errors_per_flip(NEW_EQN), count_t'(rd));
    endtask

    task automatic test_unmapped_read();
        csr_data_t rd;
        wb_read(8'h18, rd);
        check_data("unmapped read", '0, rd);
        @(negedge emu_clk);
        if (wb_ack !== 1'b0) begin
            fail_run("Unmapped read gave a second ack after the master dropped strobe");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h3600_f0a9));
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        wait (emu_rst === 1'b0);
        @(posedge emu_clk);
        test_reset_values();
        test_clean_lock();
        test_single_inject();
        test_back_pressure();
        test_poly_change();
        test_unmapped_read();
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge emu_clk);
        fail_run($sformatf("Watchdog expired after %0d cycles with tests still running",
                           WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 5
) (
    output logic emu_clk,
    output logic emu_rst
);

    // 8 ns period
    initial begin
        emu_clk = 1'b0;
        forever #(HALF_PERIOD_NS) emu_clk = ~emu_clk;
    end

    // Reset held over the first few rising edges
    initial begin
        emu_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge emu_clk);
        emu_rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* src/prbs_emu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module prbs_emu_top import prbs_pkg::*, csr_pkg::*; (
    input  logic      emu_clk,
    input  logic      emu_rst,
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  csr_addr_t wb_adr_i,
    input  csr_data_t wb_dat_i,
    output csr_data_t wb_dat_o,
    output logic      wb_ack_o
);

    // Configuration from the register block
    logic       enable;
    gap_t       gap;
    prbs_eqn_t  eqn;
    logic       inj;
    lane_idx_t  inj_lane;
    logic       clear;

    // Producer, FIFO and checker handshakes
    logic       push;
    lane_word_t gen_word;
    logic       full;
    lane_word_t head_word;
    logic       empty;
    logic       pop;

    // Status back to software
    count_t     err_cnt;
    count_t     word_cnt;
    lane_word_t lock;

    prbs_csr csr_i (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .err_cnt_i  (err_cnt),
        .word_cnt_i (word_cnt),
        .lock_i     (lock),
        .enable_o   (enable),
        .gap_o      (gap),
        .eqn_o      (eqn),
        .inj_o      (inj),
        .inj_lane_o (inj_lane),
        .clear_o    (clear)
    );

    prbs_lane_gen gen_i (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .enable_i   (enable),
        .gap_i      (gap),
        .eqn_i      (eqn),
        .inj_i      (inj),
        .inj_lane_i (inj_lane),
        .full_i     (full),
        .push_o     (push),
        .word_o     (gen_word)
    );

    sample_fifo fifo_i (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .push_i  (push),
        .data_i  (gen_word),
        .pop_i   (pop),
        .data_o  (head_word),
        .full_o  (full),
        .empty_o (empty)
    );

    prbs_lane_check check_i (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .eqn_i      (eqn),
        .clear_i    (clear),
        .empty_i    (empty),
        .data_i     (head_word),
        .pop_o      (pop),
        .err_cnt_o  (err_cnt),
        .word_cnt_o (word_cnt),
        .lock_o     (lock)
    );

endmodule

`default_nettype wire

/* src/prbs_lane_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_lane_check import prbs_pkg::*; (
    input  logic       emu_clk,
    input  logic       emu_rst,
    input  prbs_eqn_t  eqn_i,
    input  logic       clear_i,
    input  logic       empty_i,
    input  lane_word_t data_i,
    output logic       pop_o,
    output count_t     err_cnt_o,
    output count_t     word_cnt_o,
    output lane_word_t lock_o
);

    localparam int LPC        = `PRBS_LANES_PER_CYC;
    localparam int NUM_GROUPS = `PRBS_NUM_LANES / LPC;
    localparam int GRP_W      = (NUM_GROUPS > 1) ? $clog2(NUM_GROUPS) : 1;
    // Group step at which the first group takes its 32nd bit
    localparam int LOCK_STEPS = (`PRBS_WIDTH - 1) * NUM_GROUPS;
    localparam int SEEN_W     = $clog2(LOCK_STEPS + 1);

    lfsr_t             hist_q [`PRBS_NUM_LANES];
    logic [GRP_W-1:0]  grp_q;
    // Group steps since reset or clear
    logic [SEEN_W-1:0] seen_q;
    lane_word_t        lock_q;
    count_t            err_q;
    count_t            words_q;
    logic              active;
    logic              last_grp;
    logic              seen_full;
    logic [LPC-1:0]    miss;
    count_t            miss_cnt;

    assign active    = ~empty_i;
    assign last_grp  = (grp_q == GRP_W'(NUM_GROUPS - 1));
    assign seen_full = (seen_q == SEEN_W'(LOCK_STEPS));
    assign pop_o     = active & last_grp;

    // Predict each lane from its own received history
    always_comb begin
        int lane;
        miss_cnt = '0;
        for (int j = 0; j < LPC; j++) begin
            lane     = int'(grp_q) * LPC + j;
            miss[j]  = lock_q[lane] & ((^(hist_q[lane] & eqn_i)) ^ data_i[lane]);
            miss_cnt = miss_cnt + count_t'(miss[j]);
        end
    end

    always_ff @(posedge emu_clk) begin
        if (active) begin
            for (int j = 0; j < LPC; j++) begin
                hist_q[int'(grp_q) * LPC + j] <=
                    {hist_q[int'(grp_q) * LPC + j][`PRBS_WIDTH-2:0],
                     data_i[int'(grp_q) * LPC + j]};
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Group walk, lock and counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            grp_q   <= '0;
            seen_q  <= '0;
            lock_q  <= '0;
            err_q   <= '0;
            words_q <= '0;
        end else begin
            // Group walk is kept on clear so no lane sees a bit twice
            if (active) begin
                grp_q <= last_grp ? '0 : grp_q + 1'b1;
            end
            if (clear_i) begin
                seen_q  <= '0;
                lock_q  <= '0;
                err_q   <= '0;
                words_q <= '0;
            end else if (active) begin
                err_q <= err_q + miss_cnt;
                // From here on each group in turn takes its 32nd bit
                if (seen_full) begin
                    for (int j = 0; j < LPC; j++) begin
                        lock_q[int'(grp_q) * LPC + j] <= 1'b1;
                    end
                end else begin
                    seen_q <= seen_q + 1'b1;
                end
                if (last_grp) begin
                    words_q <= words_q + 1'b1;
                end
            end
        end
    end

    assign err_cnt_o  = err_q;
    assign word_cnt_o = words_q;
    assign lock_o     = lock_q;

endmodule

`default_nettype wire

/* src/sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module sample_fifo import prbs_pkg::*; (
    input  logic       emu_clk,
    input  logic       emu_rst,
    input  logic       push_i,
    input  lane_word_t data_i,
    input  logic       pop_i,
    output lane_word_t data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int DEPTH = `PRBS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    lane_word_t       mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* src/prbs_lane_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_lane_gen import prbs_pkg::*; (
    input  logic       emu_clk,
    input  logic       emu_rst,
    input  logic       enable_i,
    input  gap_t       gap_i,
    input  prbs_eqn_t  eqn_i,
    input  logic       inj_i,
    input  lane_idx_t  inj_lane_i,
    input  logic       full_i,
    output logic       push_o,
    output lane_word_t word_o
);

    gap_t       cnt_q;
    logic       pend_q;
    logic       inj_pend_q;
    lane_idx_t  inj_lane_q;
    logic       term;
    logic       due;
    lfsr_t      lfsr_q [`PRBS_NUM_LANES];
    lane_word_t next_bits;
    lane_word_t inj_mask;

    // Feedback bit of each lane is also its output bit
    always_comb begin
        for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
            next_bits[i] = ^(lfsr_q[i] & eqn_i);
        end
    end

    assign inj_mask = inj_pend_q ? (lane_word_t'(1) << inj_lane_q) : '0;
    assign word_o   = next_bits ^ inj_mask;

    // >= so a gap lowered below the count still wraps at once
    assign term   = (cnt_q >= gap_i);
    assign due    = pend_q | (enable_i & term);
    assign push_o = due & ~full_i;

    ////////////////////////////////////////////////////////////////////////////
    // Cadence and stall
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            cnt_q      <= '0;
            pend_q     <= 1'b0;
            inj_pend_q <= 1'b0;
        end else begin
            // Counter parks while a stalled word waits
            if (enable_i && !pend_q) begin
                cnt_q <= term ? '0 : cnt_q + 1'b1;
            end
            pend_q <= due & full_i;
            if (inj_i) begin
                inj_pend_q <= 1'b1;
            end else if (push_o) begin
                inj_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (inj_i) begin
            inj_lane_q <= inj_lane_i;
        end
    end

    // Seeds are lane index plus one; state moves only on a push
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                lfsr_q[i] <= lfsr_t'(i + 1);
            end
        end else if (push_o) begin
            for (int i = 0; i < `PRBS_NUM_LANES; i++) begin
                lfsr_q[i] <= {lfsr_q[i][`PRBS_WIDTH-2:0], next_bits[i]};
            end
        end
    end

endmodule

`default_nettype wire

/* src/prbs_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_csr import prbs_pkg::*, csr_pkg::*; (
    input  logic       emu_clk,
    input  logic       emu_rst,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  csr_addr_t  wb_adr_i,
    input  csr_data_t  wb_dat_i,
    output csr_data_t  wb_dat_o,
    output logic       wb_ack_o,
    input  count_t     err_cnt_i,
    input  count_t     word_cnt_i,
    input  lane_word_t lock_i,
    output logic       enable_o,
    output gap_t       gap_o,
    output prbs_eqn_t  eqn_o,
    output logic       inj_o,
    output lane_idx_t  inj_lane_o,
    output logic       clear_o
);

    localparam gap_t      GAP_RESET = gap_t'(`PRBS_NUM_CHUNKS + 1);
    localparam prbs_eqn_t EQN_RESET = 32'h8020_0003;

    logic      ack_q;
    logic      req;
    logic      wr_ctrl;
    logic      wr_eqn;
    logic      wr_inj;
    csr_data_t rd_data;
    csr_data_t dat_q;
    logic      enable_q;
    gap_t      gap_q;
    prbs_eqn_t eqn_q;
    logic      inj_q;
    lane_idx_t inj_lane_q;
    logic      clear_q;

    // New cycle seen while ack is still low
    assign req     = wb_cyc_i & wb_stb_i & ~ack_q;
    assign wr_ctrl = req & wb_we_i & (wb_adr_i == CSR_CTRL);
    assign wr_eqn  = req & wb_we_i & (wb_adr_i == CSR_EQN);
    assign wr_inj  = req & wb_we_i & (wb_adr_i == CSR_INJ);

    // Read mux; INJ and unmapped offsets read back zero
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            CSR_CTRL: begin
                rd_data[CTRL_EN_BIT] = enable_q;
                rd_data[CTRL_GAP_LSB +: $bits(gap_t)] = gap_q;
            end
            CSR_EQN:   rd_data = eqn_q;
            CSR_ERRS:  rd_data = err_cnt_i;
            CSR_WORDS: rd_data = word_cnt_i;
            CSR_LOCK:  rd_data = csr_data_t'(lock_i);
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b0;
            gap_q    <= GAP_RESET;
            eqn_q    <= EQN_RESET;
            inj_q    <= 1'b0;
            clear_q  <= 1'b0;
        end else begin
            ack_q   <= req;
            inj_q   <= wr_inj;
            // Clear bit is a strobe, it never stays set
            clear_q <= wr_ctrl & wb_dat_i[CTRL_CLR_BIT];
            if (wr_ctrl) begin
                enable_q <= wb_dat_i[CTRL_EN_BIT];
                gap_q    <= wb_dat_i[CTRL_GAP_LSB +: $bits(gap_t)];
            end
            if (wr_eqn) begin
                eqn_q <= wb_dat_i;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (req) begin
            dat_q <= rd_data;
        end
        if (wr_inj) begin
            inj_lane_q <= wb_dat_i[$bits(lane_idx_t)-1:0];
        end
    end

    assign wb_ack_o   = ack_q;
    assign wb_dat_o   = dat_q;
    assign enable_o   = enable_q;
    assign gap_o      = gap_q;
    assign eqn_o      = eqn_q;
    assign inj_o      = inj_q;
    assign inj_lane_o = inj_lane_q;
    assign clear_o    = clear_q;

endmodule

`default_nettype wire

/* src/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone side
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] csr_data_t;

    // Byte address
    typedef logic [7:0] csr_addr_t;

    // Register map
    localparam csr_addr_t CSR_CTRL  = 8'h00;
    localparam csr_addr_t CSR_EQN   = 8'h04;
    localparam csr_addr_t CSR_INJ   = 8'h08;
    localparam csr_addr_t CSR_ERRS  = 8'h0C;
    localparam csr_addr_t CSR_WORDS = 8'h10;
    localparam csr_addr_t CSR_LOCK  = 8'h14;

    // CTRL fields
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;
    localparam int CTRL_GAP_LSB = 4;

endpackage

`default_nettype wire

/* src/prbs_pkg.sv */
`default_nettype none

`include "prbs_consts.svh"

package prbs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////////////////////

    // One bit per lane
    typedef logic [`PRBS_NUM_LANES-1:0] lane_word_t;

    // LFSR tap mask
    typedef logic [`PRBS_WIDTH-1:0] prbs_eqn_t;

    // Generator state and checker history, one per lane
    typedef logic [`PRBS_WIDTH-1:0] lfsr_t;

    typedef logic [$clog2(`PRBS_NUM_LANES)-1:0] lane_idx_t;

    // Error and word counters
    typedef logic [31:0] count_t;

    // Cycles between words, minus one
    typedef logic [3:0] gap_t;

endpackage

`default_nettype wire

/* src/prbs_consts.svh */
`ifndef PRBS_CONSTS_SVH
`define PRBS_CONSTS_SVH

// Lane count, also the width of one lane word
`define PRBS_NUM_LANES 16

// LFSR length and polynomial width
`define PRBS_WIDTH 32

// Chunks per word period; the reset gap is one more than this
`define PRBS_NUM_CHUNKS 4

// Words buffered between producer and checker
`define PRBS_FIFO_DEPTH 8

// Lanes the checker handles in one cycle
`define PRBS_LANES_PER_CYC 4

`endif
